// File: filelist.f
+incdir+include
src/nnp_pkg.sv
src/nnp_layer_ctrl.sv
src/nnp_para_rom.sv
src/nnp_pe.sv
src/nnp_fmap_buf.sv
src/nnp_top.sv
testbench/nnp_props.sv
testbench/nnp_tb.sv

// File: include/nnp_macros.svh
`ifndef NNP_MACROS_SVH
`define NNP_MACROS_SVH

// ********************
// array and number format

`define NNP_PE_NUM      16  // processing elements, also the layer width
`define NNP_DATA_W      16  // q8.8 signed
`define NNP_FRAC_W      8

// ********************
// parameter rom

`define NNP_ADDR_W      6
`define NNP_ROM_DEPTH   58

// each layer is a bias row followed by one coefficient row per input
`define NNP_NET1_BASE   0
`define NNP_NET2_BASE   20

// ********************
// network shapes

// inputs taken by the first layer, later layers take the full array width
`define NNP_NET1_IN     2
`define NNP_NET2_IN     3

// layer counts including the output layer
`define NNP_NET1_DEPTH  2
`define NNP_NET2_DEPTH  3

`endif

// File: para_rom.hex
// 58 rows of 16 q8.8 words, element 15 leftmost and element 0 rightmost
// each layer is one bias row, then one coefficient row per layer input
0020ffe00010fff000300008ffd80018fff000280040ffe80010ffc800200030
00c0ff400080ffa00060ff80004000a0ff6000b0ff900070ffb00050ff7000e0
ff8000a0ffc00060ff500090ffe000c00070ff60ffa000800040ff900030ff40
0008fff80018ffe800100000fff000200000fff000180008ffe8001000280010
0030ffd00040ffc00020ffe00050ffb00010fff00060ffa00028ffd80038ffc8
ffd00030ffc00040ffe00020ffb00050fff00010ffa00060ffd80028ffc80038
0048ffb80018ffe80058ffa80028ffd80068ff980008fff80038ffc80070ff90
ffb80048ffe80018ffa80058ffd80028ff980068fff80008ffc80038ff900070
00200030ffe000100040ffc00030ffd00018ffe80048ffb80060ffa00010fff0
ffe0fff000200040ffc000500030ffb0ffe8ffd800280050ffa00060fff00020
0033ffcd001bffe50047ffb90026ffda0051ffaf0012ffee003cffc4000dfff3
ffcd0033ffe5001bffb90047ffda0026ffaf0051ffee0012ffc4003cfff3000d
00400040ffc0ffc000200020ffe0ffe000600060ffa0ffa000100010fff0fff0
ffc0ffc000400040ffe0ffe000200020ffa0ffa000600060fff0fff000100010
0070ff900030ffd00050ffb00010fff00060ffa00020ffe00040ffc00080ff80
ff9000700030ffd0ffb000500010fff0ffa000600020ffe0ffc000400080ff80
001c0024ffdcffe4002c0034ffccffd4003c0044ffbcffc4004c0054ffacffb4
ffe4ffdc0024001cffd4ffcc0034002cffc4ffbc0044003cffb4ffac0054004c
0012ffee0024ffdc0036ffca0048ffb8005affa6006cff94007eff820009fff7
ffee0012ffdc0024ffca0036ffb80048ffa6005aff94006cff82007efff70009
fff00020ffe800100018fff800280000ffd80030fff8000800100018ffe00020
0090ff700060ffa0ff5000b000c0ff400040ffc0ff80008000a0ff600030ffd0
ff7000900050ffb000a0ff60ff900070ffb00050006000a0ff40ffc0ff5000c0
0030ff8000b0ffa0ff6000400070ff9000c0ffd0ffa00050ff800060ffb00090
0010fff00008fff80020ffe00018ffe80000001000080000fff8fff000200010
0040ffe00030ffd00020ffc00050ffb00018ffe80038ffc80060ffa00010fff0
ffe00040ffd00030ffc00020ffb00050ffe80018ffc80038ffa00060fff00010
0028ffd80048ffb80058ffa80068ff980078ff880008fff80038ffc80018ffe8
ffd80028ffb80048ffa80058ff980068ff880078fff80008ffc80038ffe80018
0033001bffcdffe500470026ffb9ffda00510012ffafffee003c000dffc4fff3
ffcdffe50033001bffb9ffda00470026ffafffee00510012ffc4fff3003c000d
00500030ffb0ffd000700010ff90fff000600020ffa0ffe000400040ffc0ffc0
ffb0ffd000500030ff90fff000700010ffa0ffe000600020ffc0ffc000400040
00240012ffdcffee00480036ffb8ffca006c005aff94ffa60009007efff7ff82
ffdcffee00240012ffb8ffca00480036ff94ffa6006c005afff7ff820009007e
001cffe4002cffd4003cffc4004cffb4005cffa4006cff94007cff84000cfff4
ffe4001cffd4002cffc4003cffb4004cffa4005cff94006cff84007cfff4000c
0030003000300030ffd0ffd0ffd0ffd00020ffe00020ffe00010fff00010fff0
ffd0ffd0ffd0ffd00030003000300030ffe00020ffe00020fff00010fff00010
0044ffbc0022ffde0066ff9a0011ffef0055ffab0033ffcd0077ff890008fff8
ffbc0044ffde0022ff9a0066ffef0011ffab0055ffcd0033ff890077fff80008
0018ffe80008fff80010fff00020ffe0ffe80018fff8000800280000ffd80010
0050ffb00020ffe00030ffd00040ffc00060ffa00010fff00070ff900028ffd8
ffb00050ffe00020ffd00030ffc00040ffa00060fff00010ff900070ffd80028
0038ffc80058ffa80018ffe80068ff980048ffb80078ff880028ffd80008fff8
ffc80038ffa80058ffe80018ff980068ffb80048ff880078ffd80028fff80008
001b0033ffe5ffcd00260047ffdaffb900120051ffeeffaf000d003cfff3ffc4
ffe5ffcd001b0033ffdaffb900260047ffeeffaf00120051fff3ffc4000d003c
00300050ffd0ffb000100070fff0ff9000200060ffe0ffa000400040ffc0ffc0
ffd0ffb000300050fff0ff9000100070ffe0ffa000200060ffc0ffc000400040
00120024ffeeffdc00360048ffcaffb8005a006cffa6ff94007e0009ff82fff7
ffeeffdc00120024ffcaffb800360048ffa6ff94005a006cff82fff7007e0009
ffe4001c002cffd4ffc4003c004cffb4ffa4005c006cff94ff84007c000cfff4
001cffe4ffd4002c003cffc4ffb4004c005cffa4ff94006c007cff84fff4000c
0020002000200020ffe0ffe0ffe0ffe00030ffd00030ffd00040ffc00040ffc0
ffe0ffe0ffe0ffe00020002000200020ffd00030ffd00030ffc00040ffc00040
0022ffde0044ffbc0011ffef0066ff9a0033ffcd0055ffab0008fff80077ff89
ffde0022ffbc0044ffef0011ff9a0066ffcd0033ffab0055fff80008ff890077

// File: run.sh
#!/bin/sh
# build with verilator, run into sim.log, then search the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module nnp_tb \
  -f filelist.f -o nnp_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/nnp_sim > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

// File: src/nnp_fmap_buf.sv
`timescale 1ns/100ps
`include "nnp_macros.svh"

module nnp_fmap_buf (
  input  logic           clk,
  input  logic           rst,
  input  logic           start_i,
  input  nnp_pkg::data_t in_0_i,
  input  nnp_pkg::data_t in_1_i,
  input  nnp_pkg::data_t in_2_i,
  input  nnp_pkg::idx_t  rd_idx_i,
  input  logic           first_layer_i,
  input  logic           layer_wr_i,
  input  nnp_pkg::fmap_t wr_data_i,
  output nnp_pkg::data_t fmap_o
);

  nnp_pkg::data_t in_0_d, in_1_d, in_2_d;  // values present when the request was taken
  nnp_pkg::data_t in_0_q, in_1_q, in_2_q;
  nnp_pkg::fmap_t bank [0:1];
  logic           wr_sel;                  // bank being filled, the other one is read
  nnp_pkg::data_t rd_val;

  // start is the ack, one cycle after sampling, so keep a one cycle copy
  always_ff @(posedge clk)
  begin
    in_0_d <= in_0_i;
    in_1_d <= in_1_i;
    in_2_d <= in_2_i;
    if (start_i)
    begin
      in_0_q <= in_0_d;
      in_1_q <= in_1_d;
      in_2_q <= in_2_d;
    end
  end

  // ********************
  // ping-pong banks

  always_ff @(posedge clk)
  begin
    if (layer_wr_i)
      bank[wr_sel] <= wr_data_i;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      wr_sel <= 1'b0;
    else if (layer_wr_i)
      wr_sel <= ~wr_sel;  // freshly written layer becomes the read bank
  end

  assign rd_val = bank[~wr_sel][rd_idx_i*`NNP_DATA_W +: `NNP_DATA_W];

  always_ff @(posedge clk)
  begin
    if (first_layer_i)
    begin
      case (rd_idx_i)
        nnp_pkg::idx_t'(0): fmap_o <= in_0_q;
        nnp_pkg::idx_t'(1): fmap_o <= in_1_q;
        default:            fmap_o <= in_2_q;
      endcase
    end
    else
      fmap_o <= rd_val[`NNP_DATA_W-1] ? '0 : rd_val;  // relu
  end

endmodule

// File: src/nnp_layer_ctrl.sv
`timescale 1ns/100ps
`include "nnp_macros.svh"

module nnp_layer_ctrl (
  input  logic                clk,
  input  logic                rst,
  input  logic                req_i,
  input  nnp_pkg::net_type_t  net_type_i,
  output logic                ack_o,
  output nnp_pkg::para_addr_t para_addr_o,
  output logic                bias_load_o,
  output logic                coef_en_o,
  output nnp_pkg::idx_t       rd_idx_o,
  output logic                first_layer_o,
  output logic                layer_wr_o,
  output logic                done_o
);

  // bias row is held long enough that the next layer's first read
  // sees the previous layer already written back
  localparam int unsigned BIAS_CYC = 4;
  localparam int unsigned PIPE_LEN = 5;  // last coef state to element sum valid

  nnp_pkg::ctrl_state_t state_q;
  nnp_pkg::ctrl_state_t state_d;
  nnp_pkg::idx_t        idx_q;    // bias hold count or input index
  nnp_pkg::layer_t      layer_q;
  logic                 net2_q;
  nnp_pkg::idx_t        last_in;
  logic                 last_layer;
  logic                 req_ok;
  logic                 bias_end;
  logic                 coef_end;
  logic [1:0]           bias_sh;  // rom latency
  logic [1:0]           coef_sh;
  logic [PIPE_LEN-1:0]  wr_sh;
  logic [PIPE_LEN-1:0]  end_sh;

  assign req_ok = (state_q == nnp_pkg::ST_IDLE) && req_i &&
                  ((net_type_i == nnp_pkg::net_type_t'(1)) ||
                   (net_type_i == nnp_pkg::net_type_t'(2)));

  always_comb
  begin
    if (layer_q != '0)
      last_in = nnp_pkg::idx_t'(`NNP_PE_NUM - 1);
    else if (net2_q)
      last_in = nnp_pkg::idx_t'(`NNP_NET2_IN - 1);
    else
      last_in = nnp_pkg::idx_t'(`NNP_NET1_IN - 1);
  end

  assign last_layer = net2_q ? (layer_q == nnp_pkg::layer_t'(`NNP_NET2_DEPTH - 1))
                             : (layer_q == nnp_pkg::layer_t'(`NNP_NET1_DEPTH - 1));
  assign bias_end = (state_q == nnp_pkg::ST_BIAS) && (idx_q == nnp_pkg::idx_t'(BIAS_CYC - 1));
  assign coef_end = (state_q == nnp_pkg::ST_COEF) && (idx_q == last_in);

  // ********************
  // fsm

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      nnp_pkg::ST_IDLE: if (req_ok) state_d = nnp_pkg::ST_BIAS;
      nnp_pkg::ST_BIAS: if (bias_end) state_d = nnp_pkg::ST_COEF;
      nnp_pkg::ST_COEF:
      begin
        if (coef_end)
          state_d = last_layer ? nnp_pkg::ST_END : nnp_pkg::ST_BIAS;
      end
      nnp_pkg::ST_END:  if (done_o) state_d = nnp_pkg::ST_IDLE;  // wait for the array to drain
      default:          state_d = nnp_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q     <= nnp_pkg::ST_IDLE;
      ack_o       <= 1'b0;
      idx_q       <= '0;
      layer_q     <= '0;
      net2_q      <= 1'b0;
      para_addr_o <= '0;
    end
    else
    begin
      state_q <= state_d;
      ack_o   <= req_ok;
      if (req_ok)
      begin
        net2_q      <= (net_type_i == nnp_pkg::net_type_t'(2));
        para_addr_o <= (net_type_i == nnp_pkg::net_type_t'(2)) ?
                       nnp_pkg::para_addr_t'(`NNP_NET2_BASE) :
                       nnp_pkg::para_addr_t'(`NNP_NET1_BASE);
      end
      else if (bias_end || (state_q == nnp_pkg::ST_COEF))
        para_addr_o <= para_addr_o + 1'b1;  // rows are contiguous across layers
      if (bias_end || coef_end || (state_q == nnp_pkg::ST_IDLE))
        idx_q <= '0;
      else if ((state_q == nnp_pkg::ST_BIAS) || (state_q == nnp_pkg::ST_COEF))
        idx_q <= idx_q + 1'b1;
      if (state_q == nnp_pkg::ST_IDLE)
        layer_q <= '0;
      else if (coef_end && !last_layer)
        layer_q <= layer_q + 1'b1;
    end
  end

  // ********************
  // strobe alignment

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      bias_sh       <= '0;
      coef_sh       <= '0;
      wr_sh         <= '0;
      end_sh        <= '0;
      rd_idx_o      <= '0;
      first_layer_o <= 1'b0;
    end
    else
    begin
      bias_sh       <= {bias_sh[0], state_q == nnp_pkg::ST_BIAS};
      coef_sh       <= {coef_sh[0], state_q == nnp_pkg::ST_COEF};
      wr_sh         <= {wr_sh[PIPE_LEN-2:0], coef_end};
      end_sh        <= {end_sh[PIPE_LEN-2:0], coef_end && last_layer};
      rd_idx_o      <= idx_q;  // buffer adds one more cycle
      first_layer_o <= (layer_q == '0);
    end
  end

  assign bias_load_o = bias_sh[1];
  assign coef_en_o   = coef_sh[1];
  assign layer_wr_o  = wr_sh[PIPE_LEN-1];
  assign done_o      = end_sh[PIPE_LEN-1];

endmodule

// File: src/nnp_para_rom.sv
`timescale 1ns/100ps
`include "nnp_macros.svh"

module nnp_para_rom (
  input  logic                clk,
  input  nnp_pkg::para_addr_t addr_i,
  output nnp_pkg::para_row_t  row_o
);

  nnp_pkg::para_row_t  mem [0:`NNP_ROM_DEPTH-1];
  nnp_pkg::para_addr_t addr_q;

  // coefficients and biases of both networks
  initial
  begin
    $readmemh("para_rom.hex", mem);
  end

  // registered address and registered data
  always_ff @(posedge clk)
  begin
    addr_q <= addr_i;
    row_o  <= mem[addr_q];
  end

endmodule

// File: src/nnp_pe.sv
`timescale 1ns/100ps
`include "nnp_macros.svh"

module nnp_pe (
  input  logic           clk,
  input  logic           bias_load_i,
  input  logic           coef_en_i,
  input  nnp_pkg::data_t bias_i,
  input  nnp_pkg::data_t coef_i,
  input  nnp_pkg::data_t fmap_i,
  output nnp_pkg::data_t sum_o
);

  nnp_pkg::prod_t mul_s1;
  nnp_pkg::prod_t mul_s2;
  nnp_pkg::data_t bias_s1;
  nnp_pkg::data_t bias_s2;
  logic           ld_s1, ld_s2;
  logic           en_s1, en_s2;

  // two multiplier stages, bias rides along to stay aligned
  always_ff @(posedge clk)
  begin
    mul_s1  <= coef_i * fmap_i;
    bias_s1 <= bias_i;
    ld_s1   <= bias_load_i;
    en_s1   <= coef_en_i;
    mul_s2  <= mul_s1;
    bias_s2 <= bias_s1;
    ld_s2   <= ld_s1;
    en_s2   <= en_s1;
  end

  // back to q8.8, sum wraps in 16 bits
  always_ff @(posedge clk)
  begin
    if (ld_s2)
      sum_o <= bias_s2;
    else if (en_s2)
      sum_o <= sum_o + mul_s2[`NNP_FRAC_W +: `NNP_DATA_W];
  end

endmodule

// File: src/nnp_pkg.sv
`include "nnp_macros.svh"

package nnp_pkg;

  typedef logic signed [`NNP_DATA_W-1:0]   data_t;      // q8.8 value
  typedef logic signed [2*`NNP_DATA_W-1:0] prod_t;      // full product, q16.16

  typedef logic [`NNP_ADDR_W-1:0]              para_addr_t;
  typedef logic [`NNP_PE_NUM*`NNP_DATA_W-1:0]  para_row_t;  // element k at bits 16k and up
  typedef logic [`NNP_PE_NUM*`NNP_DATA_W-1:0]  fmap_t;      // one full layer

  typedef logic [$clog2(`NNP_PE_NUM)-1:0] idx_t;       // input index within a layer
  typedef logic [1:0]                     layer_t;
  typedef logic [7:0]                     net_type_t;  // 1 and 2 are valid

  // layer sequencer states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BIAS,
    ST_COEF,
    ST_END
  } ctrl_state_t;

endpackage

// File: src/nnp_top.sv
`timescale 1ns/100ps
`include "nnp_macros.svh"

module nnp_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               req_i,
  input  nnp_pkg::net_type_t net_type_i,
  input  nnp_pkg::data_t     in_0_i,
  input  nnp_pkg::data_t     in_1_i,
  input  nnp_pkg::data_t     in_2_i,
  output logic               ack_o,
  output logic               vld_o,
  output nnp_pkg::data_t     result_0_o,
  output nnp_pkg::data_t     result_1_o,
  output nnp_pkg::data_t     result_2_o
);

  nnp_pkg::para_addr_t para_addr;
  nnp_pkg::para_row_t  para_row;
  nnp_pkg::idx_t       rd_idx;
  nnp_pkg::data_t      fmap;
  nnp_pkg::fmap_t      pe_sum;     // all element outputs, element k at bits 16k
  logic                bias_load;
  logic                coef_en;
  logic                first_layer;
  logic                layer_wr;
  logic                done;

  nnp_layer_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .req_i         (req_i),
    .net_type_i    (net_type_i),
    .ack_o         (ack_o),
    .para_addr_o   (para_addr),
    .bias_load_o   (bias_load),
    .coef_en_o     (coef_en),
    .rd_idx_o      (rd_idx),
    .first_layer_o (first_layer),
    .layer_wr_o    (layer_wr),
    .done_o        (done)
  );

  nnp_para_rom u_rom (
    .clk    (clk),
    .addr_i (para_addr),
    .row_o  (para_row)
  );

  nnp_fmap_buf u_fmap (
    .clk           (clk),
    .rst           (rst),
    .start_i       (ack_o),
    .in_0_i        (in_0_i),
    .in_1_i        (in_1_i),
    .in_2_i        (in_2_i),
    .rd_idx_i      (rd_idx),
    .first_layer_i (first_layer),
    .layer_wr_i    (layer_wr),
    .wr_data_i     (pe_sum),
    .fmap_o        (fmap)
  );

  // ********************
  // element array

  for (genvar k = 0; k < `NNP_PE_NUM; k++)
  begin : g_pe
    nnp_pe u_pe (
      .clk         (clk),
      .bias_load_i (bias_load),
      .coef_en_i   (coef_en),
      .bias_i      (para_row[k*`NNP_DATA_W +: `NNP_DATA_W]),  // bias and coef rows share lanes
      .coef_i      (para_row[k*`NNP_DATA_W +: `NNP_DATA_W]),
      .fmap_i      (fmap),
      .sum_o       (pe_sum[k*`NNP_DATA_W +: `NNP_DATA_W])
    );
  end

  // results hold until the next request finishes
  always_ff @(posedge clk)
  begin
    if (done)
    begin
      result_0_o <= pe_sum[0*`NNP_DATA_W +: `NNP_DATA_W];
      result_1_o <= pe_sum[1*`NNP_DATA_W +: `NNP_DATA_W];
      result_2_o <= pe_sum[2*`NNP_DATA_W +: `NNP_DATA_W];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      vld_o <= 1'b0;
    else
      vld_o <= done;
  end

endmodule

// File: testbench/nnp_props.sv
`timescale 1ns/100ps

module nnp_props (
  input logic                 clk,
  input logic                 rst,
  input logic                 ack_i,
  input logic                 vld_i,
  input logic                 layer_wr_i,
  input nnp_pkg::ctrl_state_t state_i
);

  ack_single: assert property (@(posedge clk) disable iff (rst) ack_i |=> !ack_i)
    else $error("ack_o stayed high for more than one cycle");

  ack_vld_apart: assert property (@(posedge clk) disable iff (rst) !(ack_i && vld_i))
    else $error("ack_o and vld_o high in the same cycle");

  // outputs settle low on every reset edge
  reset_quiet: assert property (@(posedge clk) rst |=> (!ack_i && !vld_i))
    else $error("ack_o or vld_o high while in reset");

  wr_when_busy: assert property (@(posedge clk) disable iff (rst)
    layer_wr_i |-> (state_i != nnp_pkg::ST_IDLE))
    else $error("buffer write strobe fired while the controller was idle");

endmodule

bind nnp_top nnp_props props_i (
  .clk        (clk),
  .rst        (rst),
  .ack_i      (ack_o),
  .vld_i      (vld_o),
  .layer_wr_i (layer_wr),
  .state_i    (u_ctrl.state_q)
);

// File: testbench/nnp_tb.sv
`timescale 1ns/100ps
`include "nnp_macros.svh"

module nnp_tb;

  localparam int REQ_NUM     = 40;
  localparam int REQ_CYC     = 200;               // per request wait limit
  localparam int CYCLE_LIMIT = REQ_NUM * REQ_CYC;

  logic               clk;
  logic               rst;
  logic               req;
  nnp_pkg::net_type_t net_type;
  nnp_pkg::data_t     in_0, in_1, in_2;
  logic               ack;
  logic               vld;
  nnp_pkg::data_t     res_0, res_1, res_2;

  logic [`NNP_PE_NUM*`NNP_DATA_W-1:0] rom_img [0:`NNP_ROM_DEPTH-1];
  logic signed [15:0] exp_res [0:2];
  int                 cycle_cnt;
  int                 ack_cnt;
  int                 vld_cnt;
  int                 err_cnt;
  int                 test_cnt;
  int                 test_fail;

  nnp_top dut_i (
    .clk        (clk),
    .rst        (rst),
    .req_i      (req),
    .net_type_i (net_type),
    .in_0_i     (in_0),
    .in_1_i     (in_1),
    .in_2_i     (in_2),
    .ack_o      (ack),
    .vld_o      (vld),
    .result_0_o (res_0),
    .result_1_o (res_1),
    .result_2_o (res_2)
  );

  always #5 clk = ~clk;

  // pulse counters, sampled mid cycle
  always @(negedge clk)
  begin
    if (ack)
      ack_cnt++;
    if (vld)
      vld_cnt++;
  end

  // ********************
  // reference model

  task automatic compute_network(input nnp_pkg::net_type_t t, input nnp_pkg::data_t x0,
                                 input nnp_pkg::data_t x1, input nnp_pkg::data_t x2);
    logic signed [15:0] act [0:15];
    logic signed [15:0] acc [0:15];
    logic signed [15:0] c;
    logic signed [31:0] prod;
    logic signed [31:0] prod_sh;
    int row;
    int n_in;
    int depth;
    for (int k = 0; k < 16; k++)
      act[k] = '0;
    act[0] = x0;
    act[1] = x1;
    act[2] = x2;
    row   = (t == 8'd2) ? `NNP_NET2_BASE : `NNP_NET1_BASE;
    n_in  = (t == 8'd2) ? `NNP_NET2_IN : `NNP_NET1_IN;
    depth = (t == 8'd2) ? `NNP_NET2_DEPTH : `NNP_NET1_DEPTH;
    for (int l = 0; l < depth; l++)
    begin
      for (int k = 0; k < 16; k++)
        acc[k] = rom_img[row][k*16 +: 16];      // bias row
      row++;
      for (int i = 0; i < n_in; i++)
      begin
        for (int k = 0; k < 16; k++)
        begin
          c       = rom_img[row][k*16 +: 16];
          prod    = c * act[i];
          prod_sh = prod >>> 8;
          acc[k]  = acc[k] + prod_sh[15:0];     // wraps in 16 bits
        end
        row++;
      end
      for (int k = 0; k < 16; k++)
        act[k] = acc[k][15] ? 16'sd0 : acc[k];  // relu as seen by the next layer
      n_in = 16;
    end
    for (int k = 0; k < 3; k++)
      exp_res[k] = acc[k];
  endtask

  function automatic nnp_pkg::data_t random_data();
    int v;
    v = int'($urandom_range(1024)) - 512;       // -2.0 to +2.0
    return v[15:0];
  endfunction

  // ********************
  // checks and handshake

  task automatic check_value(input string name, input logic [15:0] exp_v,
                             input logic [15:0] act_v);
    if (act_v !== exp_v)
    begin
      $display("error: time %0t signal %s expected %h actual %h", $time, name, exp_v, act_v);
      err_cnt++;
    end
  endtask

  // holds req until ack or the wait limit, returns just after the edge that raised ack
  task automatic send_request(input nnp_pkg::net_type_t t, input nnp_pkg::data_t x0,
                              input nnp_pkg::data_t x1, input nnp_pkg::data_t x2,
                              output bit acked);
    int n;
    net_type = t;
    in_0     = x0;
    in_1     = x1;
    in_2     = x2;
    req      = 1'b1;
    acked    = 1'b0;
    n        = 0;
    while (!acked && n < REQ_CYC)
    begin
      @(posedge clk);
      #1;
      acked = ack;
      n++;
    end
    req = 1'b0;
  endtask

  task automatic finish_request(input nnp_pkg::net_type_t t, input int ack_before);
    bit got;
    int n;
    got = 1'b0;
    n   = 0;
    while (!got && n < REQ_CYC)
    begin
      @(posedge clk);
      #1;
      got = vld;
      n++;
    end
    if (!got)
    begin
      $display("no vld_o within %0d cycles for a network %0d request", REQ_CYC, t);
      err_cnt++;
    end
    else
    begin
      check_value("result_0_o", exp_res[0], res_0);
      check_value("result_1_o", exp_res[1], res_1);
      if (t == 8'd2)
        check_value("result_2_o", exp_res[2], res_2);
      @(posedge clk);
      #1;
      if (vld)
      begin
        $display("error: time %0t signal vld_o expected 0 actual 1", $time);  // one cycle pulse
        err_cnt++;
      end
    end
    if (ack_cnt - ack_before != 1)
    begin
      $display("error: time %0t signal ack_o expected 1 pulses actual %0d pulses",
               $time, ack_cnt - ack_before);
      err_cnt++;
    end
  endtask

  task automatic run_request(input nnp_pkg::net_type_t t);
    nnp_pkg::data_t x0, x1, x2;
    bit             acked;
    int             a0;
    x0 = random_data();
    x1 = random_data();
    x2 = random_data();
    compute_network(t, x0, x1, x2);
    a0 = ack_cnt;
    send_request(t, x0, x1, x2, acked);
    if (!acked)
    begin
      $display("no ack_o within %0d cycles for a network %0d request", REQ_CYC, t);
      err_cnt++;
    end
    else
      finish_request(t, a0);
  endtask

  task automatic close_test(input string name, input int err_before);
    test_cnt++;
    if (err_cnt == err_before)
      $display("test %s: pass", name);
    else
    begin
      test_fail++;
      $display("test %s: fail with %0d errors", name, err_cnt - err_before);
    end
  endtask

  // ********************
  // stimulus

  initial
  begin
    int                 err0;
    int                 a0;
    int                 v0;
    int                 r;
    bit                 acked;
    nnp_pkg::net_type_t bad [0:2];
    nnp_pkg::data_t     x0, x1, x2;
    clk       = 1'b0;
    rst       = 1'b1;
    req       = 1'b0;
    net_type  = '0;
    in_0      = '0;
    in_1      = '0;
    in_2      = '0;
    ack_cnt   = 0;
    vld_cnt   = 0;
    err_cnt   = 0;
    test_cnt  = 0;
    test_fail = 0;
    void'($urandom(32'hc186));
    $readmemh("para_rom.hex", rom_img);
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    err0 = err_cnt;
    repeat (20)
    begin
      @(posedge clk);
      #1;
    end
    if (ack_cnt != 0 || vld_cnt != 0)
    begin
      $display("ack_o or vld_o pulsed while no request was pending");
      err_cnt++;
    end
    close_test("idle_after_reset", err0);

    err0 = err_cnt;
    repeat (20) run_request(8'd1);
    close_test("net1_random", err0);

    err0 = err_cnt;
    repeat (20) run_request(8'd2);
    close_test("net2_random", err0);

    // invalid codes, then one valid request
    err0   = err_cnt;
    r      = int'($urandom_range(255, 3));
    bad[0] = 8'd0;
    bad[1] = 8'd255;
    bad[2] = r[7:0];
    for (int i = 0; i < 3; i++)
    begin
      a0 = ack_cnt;
      v0 = vld_cnt;
      send_request(bad[i], random_data(), random_data(), random_data(), acked);
      if (acked || ack_cnt != a0 || vld_cnt != v0)
      begin
        $display("request with invalid network type %0d was answered", bad[i]);
        err_cnt++;
      end
    end
    run_request(8'd2);
    close_test("invalid_type", err0);

    // second request raised while the first is still running
    err0 = err_cnt;
    x0   = random_data();
    x1   = random_data();
    x2   = random_data();
    compute_network(8'd2, x0, x1, x2);
    a0 = ack_cnt;
    send_request(8'd2, x0, x1, x2, acked);
    if (!acked)
    begin
      $display("no ack_o within %0d cycles for the busy test request", REQ_CYC);
      err_cnt++;
    end
    else
    begin
      req      = 1'b1;
      net_type = 8'd1;
      in_0     = random_data();
      in_1     = random_data();
      in_2     = random_data();
      repeat (6)
      begin
        @(posedge clk);
        #1;
      end
      req = 1'b0;
      finish_request(8'd2, a0);
    end
    close_test("req_while_busy", err0);

    $display("tests %0d, failed %0d, errors %0d", test_cnt, test_fail, err_cnt);
    if (err_cnt == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("run stopped after %0d cycles without finishing the tests", CYCLE_LIMIT);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule
